/* src/cpuDecodePkg.sv */
package cpuDecodePkg;

  localparam int instrWidth  = 16;
  localparam int idWidth     = 7;
  localparam int regWidth    = 4;
  localparam int offsetWidth = 12;
  localparam int pcWidth     = 16;
  localparam int condWidth   = regWidth + 1;  // Top bit set means no branch
  localparam int flagWidth   = 4;             // N Z C V
  localparam int condCount   = 16;

  localparam logic [regWidth-1:0] regLr = 4'd13;
  localparam logic [regWidth-1:0] regSp = 4'd14;
  localparam logic [regWidth-1:0] regPc = 4'd15;

  // Major opcode in instruction[15:12]
  typedef enum logic [3:0] {
    OpShiftImm      = 4'd0,
    OpAddSub        = 4'd1,
    OpMovCmpImm     = 4'd2,
    OpAddSubImm     = 4'd3,
    OpAluReg        = 4'd4,
    OpLoadStoreReg  = 4'd5,
    OpLoadStoreWord = 4'd6,
    OpLoadStoreByte = 4'd7,
    OpLoadStoreHalf = 4'd8,
    OpSpRelative    = 4'd9,
    OpLoadAddr      = 4'd10,
    OpMisc          = 4'd11,
    OpSwi           = 4'd12,
    OpBranchImm     = 4'd13,
    OpHltNop        = 4'd14,
    OpReset         = 4'd15
  } opcode_e;

  typedef enum logic [3:0] {
    CondEq       = 4'd0,
    CondNe       = 4'd1,
    CondCs       = 4'd2,
    CondCc       = 4'd3,
    CondMi       = 4'd4,
    CondPl       = 4'd5,
    CondVs       = 4'd6,
    CondVc       = 4'd7,
    CondHi       = 4'd8,
    CondLs       = 4'd9,
    CondGe       = 4'd10,
    CondLt       = 4'd11,
    CondGt       = 4'd12,
    CondLe       = 4'd13,
    CondAl       = 4'd14,
    CondAlways15 = 4'd15
  } condCode_e;

  typedef logic [idWidth-1:0] instrId_t;

  localparam instrId_t IdBx        = 7'h26;
  localparam instrId_t IdBxRet     = 7'h4c;  // BX with code 15
  localparam instrId_t IdSwi       = 7'h48;
  localparam instrId_t IdBranchImm = 7'h49;
  localparam instrId_t IdNop       = 7'h4a;
  localparam instrId_t IdHlt       = 7'h4b;
  localparam instrId_t IdBiosExit  = 7'h4d;
  localparam instrId_t IdResetWord = 7'h64;
  localparam instrId_t IdIllegal   = 7'h7f;

  localparam logic [condWidth-1:0]   noBranch     = 5'h1f;
  localparam logic [offsetWidth-1:0] swiVector    = 12'd9;
  localparam logic [offsetWidth-1:0] biosExitAddr = 12'd2048;

endpackage

/* src/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf import cpuDecodePkg::*; ();

  instrId_t               id;
  logic [regWidth-1:0]    regD;
  logic [regWidth-1:0]    regA;
  logic [regWidth-1:0]    regB;
  logic [offsetWidth-1:0] offset;
  logic [condWidth-1:0]   branchCondition;  // noBranch when not a branch

  modport source (
    output id, regD, regA, regB, offset, branchCondition
  );

  modport sink (
    input id, regD, regA, regB, offset, branchCondition
  );

endinterface

/* src/instructionDecoder.sv */
`timescale 1ns/1ps

module instructionDecoder import cpuDecodePkg::*; (
  input  logic [instrWidth-1:0] instruction,
  input  logic                  isBios,
  decodeIf.source               dec
);

  opcode_e    opcode;
  logic       op;
  logic [1:0] addSubSel;
  logic [1:0] funct1;
  logic [3:0] funct2;
  logic [2:0] aux;

  assign opcode    = opcode_e'(instruction[15:12]);
  assign op        = instruction[11];
  assign addSubSel = instruction[10:9];  // Opcode 1 only
  assign funct1    = instruction[7:6];
  assign funct2    = instruction[11:8];
  assign aux       = instruction[11:9];

  always_comb begin
    dec.id              = '0;
    dec.regD            = '0;
    dec.regA            = '0;
    dec.regB            = '0;
    dec.offset          = '0;
    dec.branchCondition = noBranch;

    case (opcode)
      OpShiftImm: begin
        dec.id     = op ? 7'h02 : 7'h01;
        dec.offset = {7'h0, instruction[10:6]};  // Shift amount
        dec.regD   = {1'b0, instruction[2:0]};
        dec.regA   = {1'b0, instruction[5:3]};
      end

      OpAddSub: begin
        dec.regD = {1'b0, instruction[2:0]};
        dec.regA = {1'b0, instruction[5:3]};
        if (!op) begin
          dec.id     = 7'h03;  // ASR immediate
          dec.offset = {7'h0, instruction[10:6]};
        end else begin
          case (addSubSel)
            2'd0: begin
              dec.id   = 7'h04;
              dec.regB = {1'b0, instruction[8:6]};
            end
            2'd1: begin
              dec.id   = 7'h05;
              dec.regB = {1'b0, instruction[8:6]};
            end
            2'd2: begin
              dec.id     = 7'h06;
              dec.offset = {9'h0, instruction[8:6]};
            end
            default: begin
              dec.id     = 7'h07;
              dec.offset = {9'h0, instruction[8:6]};
            end
          endcase
        end
      end

      OpMovCmpImm: begin
        dec.id     = op ? 7'h09 : 7'h08;
        dec.offset = {4'h0, instruction[7:0]};
        dec.regD   = {1'b0, instruction[10:8]};
        dec.regA   = {1'b0, instruction[10:8]};
      end

      OpAddSubImm: begin
        dec.id     = op ? 7'h0b : 7'h0a;
        dec.offset = {4'h0, instruction[7:0]};
        dec.regD   = {1'b0, instruction[10:8]};
        dec.regA   = {1'b0, instruction[10:8]};
      end

      OpAluReg: begin
        if (op) begin
          // PC-relative load
          dec.id     = 7'h27;
          dec.offset = {4'h0, instruction[7:0]};
          dec.regD   = {1'b0, instruction[10:8]};
          dec.regA   = regPc;
          dec.regB   = {1'b0, instruction[10:8]};
        end else begin
          dec.regD = {1'b0, instruction[2:0]};
          dec.regA = {1'b0, instruction[2:0]};
          dec.regB = {1'b0, instruction[5:3]};
          case (funct2)
            4'd0: dec.id = 7'h0c + funct1;  // ALU ops, four per group
            4'd1: dec.id = 7'h10 + funct1;
            4'd2: dec.id = 7'h14 + funct1;
            4'd3: dec.id = 7'h18 + funct1;
            4'd4: begin
              // Hi register ADD, bit 3 comes from funct1
              case (funct1)
                2'd1: begin
                  dec.id      = 7'h1c;
                  dec.regB[3] = 1'b1;
                end
                2'd2: begin
                  dec.id      = 7'h1d;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                end
                2'd3: begin
                  dec.id      = 7'h1e;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                  dec.regB[3] = 1'b1;
                end
                default: dec.id = 7'h0c;
              endcase
            end
            4'd5: begin
              // Hi register CMP
              case (funct1)
                2'd1: begin
                  dec.id      = 7'h1f;
                  dec.regB[3] = 1'b1;
                end
                2'd2: begin
                  dec.id      = 7'h20;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                end
                2'd3: begin
                  dec.id      = 7'h21;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                  dec.regB[3] = 1'b1;
                end
                default: dec.id = 7'h0c;
              endcase
            end
            4'd6: begin
              // Hi register MOV
              case (funct1)
                2'd0: dec.id = 7'h22;
                2'd1: begin
                  dec.id      = 7'h23;
                  dec.regB[3] = 1'b1;
                end
                2'd2: begin
                  dec.id      = 7'h24;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                end
                default: begin
                  dec.id      = 7'h25;
                  dec.regD[3] = 1'b1;
                  dec.regA[3] = 1'b1;
                  dec.regB[3] = 1'b1;
                end
              endcase
            end
            4'd7: begin
              // BX, condition in [7:4], code 15 is the return form
              dec.branchCondition = {1'b0, instruction[7:4]};
              dec.id   = (instruction[7:4] == CondAlways15) ? IdBxRet : IdBx;
              dec.regD = '0;
              dec.regA = regPc;
              dec.regB = {1'b0, instruction[2:0]};
            end
            default: dec.id = IdIllegal;
          endcase
        end
      end

      OpLoadStoreReg: begin
        dec.id   = 7'h28 + aux;
        dec.regD = {1'b0, instruction[2:0]};
        dec.regA = {1'b0, instruction[5:3]};
        dec.regB = {1'b0, instruction[8:6]};
      end

      OpLoadStoreWord, OpLoadStoreByte, OpLoadStoreHalf: begin
        // Pairs of IDs from 0x30, op picks load or store
        dec.id     = 7'h30 + {opcode - OpLoadStoreWord, op};
        dec.regD   = {1'b0, instruction[2:0]};
        dec.regA   = {1'b0, instruction[5:3]};
        dec.offset = {7'h0, instruction[10:6]};
      end

      OpSpRelative: begin
        dec.id     = op ? 7'h37 : 7'h36;
        dec.offset = {4'h0, instruction[7:0]};
        dec.regD   = {1'b0, instruction[10:8]};
        dec.regA   = regSp;
      end

      OpLoadAddr: begin
        dec.id     = op ? 7'h39 : 7'h38;
        dec.offset = {4'h0, instruction[7:0]};
        dec.regD   = {1'b0, instruction[10:8]};
        dec.regA   = op ? regSp : regPc;
      end

      OpMisc: begin
        case (funct2)
          4'd0: dec.id = 7'h3a;
          4'd2, 4'd10: begin
            dec.id   = ((funct2 == 4'd2) ? 7'h3b : 7'h3f) + funct1;
            dec.regD = {1'b0, instruction[2:0]};
            dec.regB = {1'b0, instruction[5:3]};
          end
          4'd4: begin
            dec.id   = 7'h43;
            dec.regD = {1'b0, instruction[2:0]};
          end
          4'd13: begin
            dec.id   = 7'h44;
            dec.regD = {1'b0, instruction[2:0]};
          end
          4'd14: begin
            case (funct1)
              2'd0: begin
                dec.id   = 7'h45;  // OUTPUT
                dec.regD = {1'b0, instruction[2:0]};
              end
              2'd1: dec.id = 7'h46;  // PAUSE
              2'd2: begin
                dec.id   = 7'h47;  // INPUT
                dec.regD = {1'b0, instruction[2:0]};
              end
              default: dec.id = IdIllegal;
            endcase
          end
          default: dec.id = IdIllegal;
        endcase
      end

      OpSwi: begin
        dec.id              = IdSwi;
        dec.offset          = swiVector;
        dec.regB            = regLr;  // Return address goes here
        dec.branchCondition = {1'b0, CondAl};
      end

      OpBranchImm: begin
        dec.id              = IdBranchImm;
        dec.branchCondition = {1'b0, instruction[11:8]};
        dec.offset          = {4'h0, instruction[7:0]};
        dec.regA            = regPc;
      end

      OpHltNop: begin
        if (op && isBios) begin
          // HLT inside BIOS leaves to user code
          dec.id              = IdBiosExit;
          dec.branchCondition = {1'b0, CondAlways15};
          dec.offset          = biosExitAddr;
          dec.regA            = regPc;
        end else begin
          dec.id = op ? IdHlt : IdNop;
        end
      end

      OpReset: dec.id = (instruction == 16'hffff) ? IdResetWord : IdIllegal;

      default: dec.id = IdIllegal;
    endcase
  end

endmodule

/* src/conditionEvaluator.sv */
`timescale 1ns/1ps

module conditionEvaluator import cpuDecodePkg::*; (
  input  logic [flagWidth-1:0] flags,
  output logic [condCount-1:0] condMet
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic hi;
  logic ge;
  logic gt;

  assign n = flags[3];
  assign z = flags[2];
  assign c = flags[1];
  assign v = flags[0];

  assign hi = c & ~z;    // Unsigned higher
  assign ge = (n == v);  // Signed greater or equal
  assign gt = ~z & ge;

  // Every code in parallel, the stage picks one
  always_comb begin
    condMet               = '0;
    condMet[CondEq]       = z;
    condMet[CondNe]       = ~z;
    condMet[CondCs]       = c;
    condMet[CondCc]       = ~c;
    condMet[CondMi]       = n;
    condMet[CondPl]       = ~n;
    condMet[CondVs]       = v;
    condMet[CondVc]       = ~v;
    condMet[CondHi]       = hi;
    condMet[CondLs]       = ~hi;
    condMet[CondGe]       = ge;
    condMet[CondLt]       = ~ge;
    condMet[CondGt]       = gt;
    condMet[CondLe]       = ~gt;
    condMet[CondAl]       = 1'b1;
    condMet[CondAlways15] = 1'b1;
  end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import cpuDecodePkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [pcWidth-1:0]     pc,
  input  logic [condCount-1:0]   condMet,
  decodeIf.sink                  dec,
  output logic                   decValid,
  output instrId_t               decId,
  output logic [regWidth-1:0]    regD,
  output logic [regWidth-1:0]    regA,
  output logic [regWidth-1:0]    regB,
  output logic [offsetWidth-1:0] offset,
  output logic                   branchTaken,
  output logic [pcWidth-1:0]     branchTarget
);

  logic               absTarget;
  logic               takenNext;
  logic [pcWidth-1:0] targetNext;

  assign absTarget = (dec.id == IdSwi) || (dec.id == IdBiosExit);  // Fixed vectors

  // noBranch has the top bit set and is never taken
  assign takenNext = ~dec.branchCondition[condWidth-1]
                   & condMet[dec.branchCondition[condWidth-2:0]];

  assign targetNext = absTarget ? pcWidth'(dec.offset)
                                : pc + pcWidth'(dec.offset);  // Wraps at 64K

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid     <= 1'b0;
      decId        <= '0;
      regD         <= '0;
      regA         <= '0;
      regB         <= '0;
      offset       <= '0;
      branchTaken  <= 1'b0;
      branchTarget <= '0;
    end else begin
      decValid <= instrValid;  // One pulse per accepted word
      if (instrValid) begin
        decId        <= dec.id;
        regD         <= dec.regD;
        regA         <= dec.regA;
        regB         <= dec.regB;
        offset       <= dec.offset;
        branchTaken  <= takenNext;
        branchTarget <= targetNext;
      end
    end
  end

endmodule

/* src/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit import cpuDecodePkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [instrWidth-1:0]  instruction,
  input  logic                   isBios,
  input  logic [pcWidth-1:0]     pc,
  input  logic [flagWidth-1:0]   flags,  // NZCV
  output logic                   decValid,
  output instrId_t               decId,
  output logic [regWidth-1:0]    regD,
  output logic [regWidth-1:0]    regA,
  output logic [regWidth-1:0]    regB,
  output logic [offsetWidth-1:0] offset,
  output logic                   branchTaken,
  output logic [pcWidth-1:0]     branchTarget
);

  logic [condCount-1:0] condMet;

  decodeIf decBus ();

  instructionDecoder uDecoder (
    .instruction (instruction),
    .isBios      (isBios),
    .dec         (decBus.source)
  );

  conditionEvaluator uCondEval (
    .flags   (flags),
    .condMet (condMet)
  );

  decodeStage uStage (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .pc           (pc),
    .condMet      (condMet),
    .dec          (decBus.sink),
    .decValid     (decValid),
    .decId        (decId),
    .regD         (regD),
    .regA         (regA),
    .regB         (regB),
    .offset       (offset),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

endmodule

/* include/decodeRefRules.svh */
`ifndef DECODE_REF_RULES_SVH
`define DECODE_REF_RULES_SVH

typedef struct packed {
  logic [instrWidth-1:0]  instruction;
  instrId_t               id;
  logic [regWidth-1:0]    regD;
  logic [regWidth-1:0]    regA;
  logic [regWidth-1:0]    regB;
  logic [offsetWidth-1:0] offset;
} decodeVec_t;

localparam int dirCount = 19;

// Instruction, ID, regD, regA, regB, offset with isBios low
localparam decodeVec_t dirTable [dirCount] = '{
  '{16'h0151, 7'h01, 4'd1,  4'd2,  4'd0,  12'h005},
  '{16'h18d1, 7'h04, 4'd1,  4'd2,  4'd3,  12'h000},
  '{16'h2355, 7'h08, 4'd3,  4'd3,  4'd0,  12'h055},
  '{16'h3c10, 7'h0b, 4'd4,  4'd4,  4'd0,  12'h010},
  '{16'h46d3, 7'h25, 4'd11, 4'd11, 4'd10, 12'h000},
  '{16'h45d3, 7'h21, 4'd11, 4'd11, 4'd10, 12'h000},
  '{16'h4a04, 7'h27, 4'd2,  4'd15, 4'd2,  12'h004},
  '{16'h4705, 7'h26, 4'd0,  4'd15, 4'd5,  12'h000},
  '{16'h47f5, 7'h4c, 4'd0,  4'd15, 4'd5,  12'h000},
  '{16'h5711, 7'h2b, 4'd1,  4'd2,  4'd4,  12'h000},
  '{16'h68d1, 7'h31, 4'd1,  4'd2,  4'd0,  12'h003},
  '{16'h709c, 7'h32, 4'd4,  4'd3,  4'd0,  12'h002},
  '{16'h8849, 7'h35, 4'd1,  4'd1,  4'd0,  12'h001},
  '{16'h9d08, 7'h37, 4'd5,  4'd14, 4'd0,  12'h008},
  '{16'ha603, 7'h38, 4'd6,  4'd15, 4'd0,  12'h003},
  '{16'hb253, 7'h3c, 4'd3,  4'd0,  4'd2,  12'h000},
  '{16'hc000, 7'h48, 4'd0,  4'd0,  4'd13, 12'h009},
  '{16'hd110, 7'h49, 4'd0,  4'd15, 4'd0,  12'h010},
  '{16'he000, 7'h4a, 4'd0,  4'd0,  4'd0,  12'h000}
};

// Codes come in pairs, odd code is the inverse of the even one
function automatic logic refCondMet(input logic [3:0] cond, input logic [3:0] nzcv);
  logic base;
  case (cond[3:1])
    3'd0: base = nzcv[2];
    3'd1: base = nzcv[1];
    3'd2: base = nzcv[3];
    3'd3: base = nzcv[0];
    3'd4: base = nzcv[1] & ~nzcv[2];
    3'd5: base = (nzcv[3] == nzcv[0]);
    3'd6: base = ~nzcv[2] & (nzcv[3] == nzcv[0]);
    default: base = 1'b1;
  endcase
  return (cond[3:1] == 3'd7) ? 1'b1 : base ^ cond[0];
endfunction

function automatic logic refTaken(input logic [4:0] branchCond, input logic [3:0] nzcv);
  return !branchCond[4] && refCondMet(branchCond[3:0], nzcv);
endfunction

function automatic logic [pcWidth-1:0] refTarget(input instrId_t id,
                                                 input logic [pcWidth-1:0] pc,
                                                 input logic [offsetWidth-1:0] off);
  if (id == IdSwi || id == IdBiosExit) return {4'h0, off};
  return pc + {4'h0, off};
endfunction

`endif

/* verification/decodeUnitTb.sv */
`timescale 1ns/1ps

module decodeUnitTb import cpuDecodePkg::*; ();

  logic                   clk = 1'b0;
  logic                   rstN;
  logic                   instrValid;
  logic [instrWidth-1:0]  instruction;
  logic                   isBios;
  logic [pcWidth-1:0]     pc;
  logic [flagWidth-1:0]   flags;
  logic                   decValid;
  instrId_t               decId;
  logic [regWidth-1:0]    regD;
  logic [regWidth-1:0]    regA;
  logic [regWidth-1:0]    regB;
  logic [offsetWidth-1:0] offset;
  logic                   branchTaken;
  logic [pcWidth-1:0]     branchTarget;

  integer seed;
  int     errorCount;
  int     testCount;
  int     failedTests;
  int     errorsAtStart;
  string  curTest;

  `include "decodeRefRules.svh"

  localparam bit streamPattern [12] = '{1, 1, 0, 1, 0, 0, 1, 1, 1, 0, 1, 1};

  decodeUnit uut (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instruction  (instruction),
    .isBios       (isBios),
    .pc           (pc),
    .flags        (flags),
    .decValid     (decValid),
    .decId        (decId),
    .regD         (regD),
    .regA         (regA),
    .regB         (regB),
    .offset       (offset),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic startTest(input string name);
    curTest       = name;
    errorsAtStart = errorCount;
    testCount++;
  endtask

  task automatic finishTest();
    if (errorCount == errorsAtStart) begin
      $display("Test %s ok", curTest);
    end else begin
      failedTests++;
      $display("Test %s had %0d errors", curTest, errorCount - errorsAtStart);
    end
  endtask

  task automatic compareId(input string what, input instrId_t expected, input instrId_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s %s: expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic compareReg(input string what, input logic [regWidth-1:0] expected,
                            input logic [regWidth-1:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s %s: expected %0d actual %0d", curTest, what, expected, actual);
    end
  endtask

  task automatic compareOffset(input string what, input logic [offsetWidth-1:0] expected,
                               input logic [offsetWidth-1:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s %s: expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic compareBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s %s: expected %b actual %b", curTest, what, expected, actual);
    end
  endtask

  task automatic compareAddr(input string what, input logic [pcWidth-1:0] expected,
                             input logic [pcWidth-1:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s %s: expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  // One word for one cycle, valid drops afterwards
  task automatic driveWord(input logic [instrWidth-1:0] word, input logic bios,
                           input logic [pcWidth-1:0] pcVal, input logic [flagWidth-1:0] nzcv);
    @(posedge clk);
    #2;
    instrValid  = 1'b1;
    instruction = word;
    isBios      = bios;
    pc          = pcVal;
    flags       = nzcv;
    @(posedge clk);
    #2;
    instrValid = 1'b0;
  endtask

  task automatic waitValid(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 10) begin
      @(negedge clk);  // Outputs settled here
      seen = decValid;
      cycles++;
    end
    if (!seen) begin
      errorCount++;
      $display("Timeout in %s: decValid did not rise within 10 cycles", curTest);
    end
  endtask

  task automatic runWord(input logic [instrWidth-1:0] word, input logic bios,
                         input logic [pcWidth-1:0] pcVal, input logic [flagWidth-1:0] nzcv,
                         input instrId_t expId, input logic expTaken,
                         input logic [pcWidth-1:0] expTarget);
    logic seen;
    driveWord(word, bios, pcVal, nzcv);
    waitValid(seen);
    if (seen) begin
      compareId("id", expId, decId);
      compareBit("branchTaken", expTaken, branchTaken);
      compareAddr("branchTarget", expTarget, branchTarget);
    end
  endtask

  task automatic resetTest();
    startTest("reset");
    rstN        = 1'b0;
    instrValid  = 1'b1;  // Reset must win over a valid word
    instruction = 16'h0151;
    isBios      = 1'b0;
    pc          = 16'h1234;
    flags       = 4'hf;
    repeat (4) @(posedge clk);
    #2;
    rstN       = 1'b1;
    instrValid = 1'b0;
    @(negedge clk);
    compareBit("decValid", 1'b0, decValid);
    compareBit("branchTaken", 1'b0, branchTaken);
    compareId("id", '0, decId);
    compareReg("regD", '0, regD);
    compareReg("regA", '0, regA);
    compareReg("regB", '0, regB);
    compareOffset("offset", '0, offset);
    compareAddr("branchTarget", '0, branchTarget);
    finishTest();
  endtask

  task automatic fieldDecodeTest();
    logic seen;
    startTest("fieldDecode");
    for (int i = 0; i < dirCount; i++) begin
      driveWord(dirTable[i].instruction, 1'b0, 16'($random(seed)), 4'($random(seed)));
      waitValid(seen);
      if (seen) begin
        compareId("id", dirTable[i].id, decId);
        compareReg("regD", dirTable[i].regD, regD);
        compareReg("regA", dirTable[i].regA, regA);
        compareReg("regB", dirTable[i].regB, regB);
        compareOffset("offset", dirTable[i].offset, offset);
      end
    end
    finishTest();
  endtask

  task automatic branchImmTest();
    logic [7:0]           off8;
    logic [flagWidth-1:0] nzcv;
    logic [pcWidth-1:0]   pcVal;
    startTest("branchImm");
    for (int round = 0; round < 4; round++) begin  // Several flag sets per code
      for (int c = 0; c < condCount; c++) begin
        off8  = 8'($random(seed));
        nzcv  = 4'($random(seed));
        pcVal = 16'($random(seed));
        runWord({4'(OpBranchImm), 4'(c), off8}, 1'b0, pcVal, nzcv, IdBranchImm,
                refTaken({1'b0, 4'(c)}, nzcv), refTarget(IdBranchImm, pcVal, {4'h0, off8}));
        compareOffset("offset", {4'h0, off8}, offset);
      end
    end
    finishTest();
  endtask

  task automatic swiHltTest();
    logic [pcWidth-1:0] pcVal;
    startTest("swiHlt");
    pcVal = 16'($random(seed));
    runWord(16'hc000, 1'b0, pcVal, 4'h0, IdSwi, 1'b1, 16'd9);
    compareReg("regB", 4'd13, regB);
    pcVal = 16'($random(seed));
    runWord(16'he800, 1'b1, pcVal, 4'h0, IdBiosExit, 1'b1, 16'd2048);
    pcVal = 16'($random(seed));
    runWord(16'he800, 1'b0, pcVal, 4'hf, IdHlt, 1'b0, refTarget(IdHlt, pcVal, '0));
    finishTest();
  endtask

  // Each check sees the word driven one cycle earlier
  task automatic streamingTest();
    logic prevValid;
    int   heldIdx;
    int   pulses;
    int   accepted;
    startTest("streaming");
    prevValid = 1'b0;
    heldIdx   = 0;
    pulses    = 0;
    accepted  = 0;
    for (int k = 0; k <= 12; k++) begin
      @(posedge clk);
      #2;
      instrValid  = (k < 12) ? streamPattern[k] : 1'b0;
      instruction = dirTable[k % dirCount].instruction;
      isBios      = 1'b0;
      @(negedge clk);
      compareBit("decValid", prevValid, decValid);
      if (decValid) begin
        pulses++;
      end
      // Last accepted word, also held through the gaps
      if (accepted > 0) begin
        compareId("id", dirTable[heldIdx].id, decId);
        compareReg("regD", dirTable[heldIdx].regD, regD);
        compareOffset("offset", dirTable[heldIdx].offset, offset);
      end
      if (instrValid) begin
        accepted++;
        heldIdx = k % dirCount;
      end
      prevValid = instrValid;
    end
    if (pulses != accepted) begin
      errorCount++;
      $display("FAILED %s pulse count: expected %0d actual %0d", curTest, accepted, pulses);
    end
    finishTest();
  endtask

  task automatic illegalTest();
    logic [instrWidth-1:0] badWords [4];
    logic [pcWidth-1:0]    pcVal;
    startTest("illegal");
    badWords = '{16'hb100, 16'hbec0, 16'hf000, 16'hfffe};  // Undefined encodings
    for (int i = 0; i < 4; i++) begin
      pcVal = 16'($random(seed));
      runWord(badWords[i], 1'b0, pcVal, 4'($random(seed)), IdIllegal, 1'b0,
              refTarget(IdIllegal, pcVal, '0));
      compareOffset("offset", '0, offset);
    end
    pcVal = 16'($random(seed));
    runWord(16'hffff, 1'b0, pcVal, 4'hf, IdResetWord, 1'b0, refTarget(IdResetWord, pcVal, '0));
    finishTest();
  endtask

  initial begin
    seed        = 37;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    resetTest();
    fieldDecodeTest();
    branchImmTest();
    swiHltTest();
    streamingTest();
    illegalTest();
    $display("Tests run %0d, tests failed %0d, check errors %0d",
             testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
src/cpuDecodePkg.sv
src/decodeIf.sv
src/instructionDecoder.sv
src/conditionEvaluator.sv
src/decodeStage.sv
src/decodeUnit.sv
verification/decodeUnitTb.sv
